// ==== common/axi_lite_pkg.sv ====
package axi_lite_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Bus widths
    ////////////////////////////////////////////////////////////////////////////

    localparam int ADDR_W = 32;             // Byte address
    localparam int DATA_W = 32;             // One memory word per beat
    localparam int STRB_W = DATA_W / 8;     // One strobe bit per byte lane

    ////////////////////////////////////////////////////////////////////////////
    // Response codes
    ////////////////////////////////////////////////////////////////////////////

    // Encoding as on the AXI BRESP / RRESP wires
    // EXOKAY and DECERR are never produced by this slave
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_t;

    ////////////////////////////////////////////////////////////////////////////
    // Memory bank FSM
    ////////////////////////////////////////////////////////////////////////////

    // One response per state, write before read
    typedef enum logic [1:0] {
        IDLE       = 2'b00,     // Nothing to report
        WRITE_RESP = 2'b01,     // write_done pulse
        READ_RESP  = 2'b10      // read_valid pulse with data
    } mem_state_t;

endpackage : axi_lite_pkg

// ==== axi_slave/axi_slave.sv ====
`timescale 1ns/1ns

module axi_slave import axi_lite_pkg::*; (
    input  logic              read_channel,
    input  logic              rst_n_i,

    // Write address channel
    input  logic [ADDR_W-1:0] awaddr_i,
    input  logic              awvalid_i,
    output logic              awready_o,

    // Write data channel
    input  logic [DATA_W-1:0] wdata_i,
    input  logic [STRB_W-1:0] wstrb_i,
    input  logic              wvalid_i,
    output logic              wready_o,

    // Write response channel
    output axi_resp_t         bresp_o,
    output logic              bvalid_o,
    input  logic              bready_i,

    // Read address channel
    input  logic [ADDR_W-1:0] araddr_i,
    input  logic              arvalid_i,
    output logic              arready_o,

    // Read data channel
    output logic [DATA_W-1:0] rdata_o,
    output axi_resp_t         rresp_o,
    output logic              rvalid_o,
    input  logic              rready_i,

    // Memory side, write
    input  logic              write_error_i,
    input  logic              write_done_i,
    output logic [ADDR_W-1:0] write_address_o,
    output logic [DATA_W-1:0] write_data_o,
    output logic [STRB_W-1:0] write_strobe_o,
    output logic              write_request_o,

    // Memory side, read
    input  logic [DATA_W-1:0] read_data_i,
    input  logic              read_valid_i,
    input  logic              read_error_i,
    output logic [ADDR_W-1:0] read_address_o,
    output logic              read_request_o,

    // Stall from the sequencer
    input  logic              stop_write_i,
    input  logic              stop_read_i
);

    ////////////////////////////////////////////////////////////////////////////
    // Write path
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge read_channel) begin : write_handshake
        if (!rst_n_i) begin
            awready_o <= 1'b1;              // Ready straight out of reset
            wready_o  <= 1'b1;
            bvalid_o  <= 1'b0;
            bresp_o   <= OKAY;
        end else begin
            // Stall one cycle after the sequencer asks for it
            awready_o <= !stop_write_i;
            wready_o  <= !stop_write_i;

            if (write_done_i) begin
                bvalid_o <= 1'b1;           // Memory finished the write
                bresp_o  <= write_error_i ? SLVERR : OKAY;
            end else if (bvalid_o && bready_i) begin
                // Master took the response
                bvalid_o <= 1'b0;
                bresp_o  <= OKAY;
            end
        end
    end : write_handshake

    // AW and W arrive together, both handshakes in one cycle
    assign write_request_o = awvalid_i & awready_o & wvalid_i & wready_o;

    assign write_address_o = awaddr_i;
    assign write_data_o    = wdata_i;
    assign write_strobe_o  = wstrb_i;

    ////////////////////////////////////////////////////////////////////////////
    // Read path
    ////////////////////////////////////////////////////////////////////////////

    // Read word, captured only when the memory presents it
    always_ff @(posedge read_channel) begin : read_payload
        if (read_valid_i) begin
            rdata_o <= read_data_i;
        end
    end : read_payload

    always_ff @(posedge read_channel) begin : read_handshake
        if (!rst_n_i) begin
            arready_o <= 1'b1;
            rvalid_o  <= 1'b0;
            rresp_o   <= OKAY;
        end else begin
            arready_o <= !stop_read_i;      // Same stall scheme as the write side

            if (read_valid_i) begin
                // Response stored with its own data word
                rvalid_o <= 1'b1;
                rresp_o  <= read_error_i ? SLVERR : OKAY;
            end else if (rvalid_o && rready_i) begin
                rvalid_o <= 1'b0;           // Data consumed
                rresp_o  <= OKAY;
            end
        end
    end : read_handshake

    // Address accepted when valid meets ready
    assign read_request_o = arvalid_i & arready_o;
    assign read_address_o = araddr_i;

endmodule : axi_slave

// ==== hdl/access_sequencer.sv ====
`timescale 1ns/1ns

module access_sequencer (
    input  logic read_channel,
    input  logic rst_n_i,

    // Accepted requests from the slave
    input  logic write_request_i,
    input  logic read_request_i,

    // Response handshakes seen on the bus
    input  logic bvalid_i,
    input  logic bready_i,
    input  logic rvalid_i,
    input  logic rready_i,

    // Stalls back to the slave
    output logic stop_write_o,
    output logic stop_read_o
);

    logic write_busy_q;     // A write is waiting for its B handshake
    logic read_busy_q;      // A read is waiting for its R handshake
    logic b_done;
    logic r_done;

    assign b_done = bvalid_i & bready_i;
    assign r_done = rvalid_i & rready_i;

    ////////////////////////////////////////////////////////////////////////////
    // Outstanding flags
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge read_channel) begin : outstanding
        if (!rst_n_i) begin
            write_busy_q <= 1'b0;
            read_busy_q  <= 1'b0;
        end else begin
            // Set on the request, cleared by the completing handshake
            if (write_request_i) begin
                write_busy_q <= 1'b1;
            end else if (b_done) begin
                write_busy_q <= 1'b0;
            end

            if (read_request_i) begin
                read_busy_q <= 1'b1;
            end else if (r_done) begin
                read_busy_q <= 1'b0;
            end
        end
    end : outstanding

    ////////////////////////////////////////////////////////////////////////////
    // Stall outputs
    ////////////////////////////////////////////////////////////////////////////

    // The request stalls in its own cycle, the handshake releases in its own cycle
    // so ready returns the cycle after the response is taken
    assign stop_write_o = (write_busy_q & ~b_done) | write_request_i;
    assign stop_read_o  = (read_busy_q & ~r_done) | read_request_i;

endmodule : access_sequencer

// ==== hdl/mem_bank.sv ====
`timescale 1ns/1ns

module mem_bank import axi_lite_pkg::*; #(
    parameter int                MEM_DEPTH = 64,    // Words, power of two
    parameter logic [ADDR_W-1:0] BASE_ADDR = '0     // Byte address of word 0
) (
    input  logic              read_channel,
    input  logic              rst_n_i,

    // Write request
    input  logic              write_request_i,
    input  logic [ADDR_W-1:0] write_address_i,
    input  logic [DATA_W-1:0] write_data_i,
    input  logic [STRB_W-1:0] write_strobe_i,

    // Read request
    input  logic              read_request_i,
    input  logic [ADDR_W-1:0] read_address_i,

    // Responses
    output logic              write_done_o,
    output logic              write_error_o,
    output logic [DATA_W-1:0] read_data_o,
    output logic              read_valid_o,
    output logic              read_error_o
);

    localparam int IDX_W = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;
    localparam logic [ADDR_W:0] LIMIT = {1'b0, BASE_ADDR} + 4 * MEM_DEPTH;  // First byte past bank

    logic [DATA_W-1:0] mem_q [MEM_DEPTH];

    mem_state_t        state_q, state_d;
    logic              read_pending_q, read_pending_d;  // Read parked behind a write
    logic [ADDR_W-1:0] pending_addr_q;
    logic              serve_read;                      // Read done at this edge
    logic [ADDR_W-1:0] rd_addr;
    logic              wr_ok, rd_ok;
    logic              write_error_q, read_error_q;
    logic [DATA_W-1:0] read_data_q;

    ////////////////////////////////////////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////////////////////////////////////////

    // Inside the bank and on a word boundary
    function automatic logic addr_ok(input logic [ADDR_W-1:0] addr);
        return (addr >= BASE_ADDR) && ({1'b0, addr} < LIMIT) && (addr[1:0] == 2'b00);
    endfunction

    function automatic logic [IDX_W-1:0] word_index(input logic [ADDR_W-1:0] addr);
        logic [ADDR_W-1:0] offset;
        offset = addr - BASE_ADDR;
        return offset[IDX_W+1:2];
    endfunction

    assign rd_addr = read_pending_q ? pending_addr_q : read_address_i;
    assign wr_ok   = addr_ok(write_address_i);
    assign rd_ok   = addr_ok(rd_addr);

    ////////////////////////////////////////////////////////////////////////////
    // Sequencing, write first then read
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin : next_state
        state_d        = IDLE;
        read_pending_d = read_pending_q;
        serve_read     = 1'b0;
        if (write_request_i) begin
            state_d        = WRITE_RESP;
            read_pending_d = read_pending_q | read_request_i;   // Colliding read waits
        end else if (read_pending_q || read_request_i) begin
            state_d        = READ_RESP;
            read_pending_d = 1'b0;
            serve_read     = 1'b1;
        end
    end : next_state

    always_ff @(posedge read_channel) begin : control
        if (!rst_n_i) begin
            state_q        <= IDLE;
            read_pending_q <= 1'b0;
            write_error_q  <= 1'b0;
            read_error_q   <= 1'b0;
        end else begin
            state_q        <= state_d;
            read_pending_q <= read_pending_d;
            if (write_request_i) write_error_q <= !wr_ok;
            if (serve_read)      read_error_q  <= !rd_ok;
        end
    end : control

    ////////////////////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge read_channel) begin : storage
        if (!rst_n_i) begin
            for (int i = 0; i < MEM_DEPTH; i++) begin
                mem_q[i] <= '0;
            end
        end else if (write_request_i && wr_ok) begin
            // Only strobed lanes change
            for (int b = 0; b < STRB_W; b++) begin
                if (write_strobe_i[b]) begin
                    mem_q[word_index(write_address_i)][8*b +: 8] <= write_data_i[8*b +: 8];
                end
            end
        end
    end : storage

    always_ff @(posedge read_channel) begin : read_port
        if (serve_read) begin
            read_data_q <= rd_ok ? mem_q[word_index(rd_addr)] : '0;   // Zero on error
        end
        if (write_request_i && read_request_i) begin
            pending_addr_q <= read_address_i;
        end
    end : read_port

    // One pulse per response, decoded from the state
    always_comb begin : outputs
        write_done_o = 1'b0;
        read_valid_o = 1'b0;
        case (state_q)
            WRITE_RESP: write_done_o = 1'b1;
            READ_RESP:  read_valid_o = 1'b1;
            default:    ;
        endcase
    end : outputs

    assign write_error_o = write_error_q;
    assign read_error_o  = read_error_q;
    assign read_data_o   = read_data_q;

endmodule : mem_bank

// ==== hdl/axi_lite_mem_top.sv ====
`timescale 1ns/1ns

module axi_lite_mem_top import axi_lite_pkg::*; #(
    parameter int                MEM_DEPTH = 64,
    parameter logic [ADDR_W-1:0] BASE_ADDR = '0
) (
    input  logic              read_channel,
    input  logic              rst_n_i,

    input  logic [ADDR_W-1:0] awaddr_i,
    input  logic              awvalid_i,
    output logic              awready_o,

    input  logic [DATA_W-1:0] wdata_i,
    input  logic [STRB_W-1:0] wstrb_i,
    input  logic              wvalid_i,
    output logic              wready_o,

    output axi_resp_t         bresp_o,
    output logic              bvalid_o,
    input  logic              bready_i,

    input  logic [ADDR_W-1:0] araddr_i,
    input  logic              arvalid_i,
    output logic              arready_o,

    output logic [DATA_W-1:0] rdata_o,
    output axi_resp_t         rresp_o,
    output logic              rvalid_o,
    input  logic              rready_i
);

    // Slave to memory
    logic              write_request;
    logic [ADDR_W-1:0] write_address;
    logic [DATA_W-1:0] write_data;
    logic [STRB_W-1:0] write_strobe;
    logic              read_request;
    logic [ADDR_W-1:0] read_address;

    // Memory to slave
    logic              write_done;
    logic              write_error;
    logic [DATA_W-1:0] read_data;
    logic              read_valid;
    logic              read_error;

    // Sequencer to slave
    logic              stop_write;
    logic              stop_read;

    ////////////////////////////////////////////////////////////////////////////
    // Bus port
    ////////////////////////////////////////////////////////////////////////////

    axi_slave u_axi_slave (
        .read_channel    (read_channel),
        .rst_n_i         (rst_n_i),
        .awaddr_i        (awaddr_i),
        .awvalid_i       (awvalid_i),
        .awready_o       (awready_o),
        .wdata_i         (wdata_i),
        .wstrb_i         (wstrb_i),
        .wvalid_i        (wvalid_i),
        .wready_o        (wready_o),
        .bresp_o         (bresp_o),
        .bvalid_o        (bvalid_o),
        .bready_i        (bready_i),
        .araddr_i        (araddr_i),
        .arvalid_i       (arvalid_i),
        .arready_o       (arready_o),
        .rdata_o         (rdata_o),
        .rresp_o         (rresp_o),
        .rvalid_o        (rvalid_o),
        .rready_i        (rready_i),
        .write_error_i   (write_error),
        .write_done_i    (write_done),
        .write_address_o (write_address),
        .write_data_o    (write_data),
        .write_strobe_o  (write_strobe),
        .write_request_o (write_request),
        .read_data_i     (read_data),
        .read_valid_i    (read_valid),
        .read_error_i    (read_error),
        .read_address_o  (read_address),
        .read_request_o  (read_request),
        .stop_write_i    (stop_write),
        .stop_read_i     (stop_read)
    );

    // Watches the response handshakes on the external wires
    access_sequencer u_access_sequencer (
        .read_channel    (read_channel),
        .rst_n_i         (rst_n_i),
        .write_request_i (write_request),
        .read_request_i  (read_request),
        .bvalid_i        (bvalid_o),
        .bready_i        (bready_i),
        .rvalid_i        (rvalid_o),
        .rready_i        (rready_i),
        .stop_write_o    (stop_write),
        .stop_read_o     (stop_read)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////////////////////

    mem_bank #(
        .MEM_DEPTH (MEM_DEPTH),
        .BASE_ADDR (BASE_ADDR)
    ) u_mem_bank (
        .read_channel    (read_channel),
        .rst_n_i         (rst_n_i),
        .write_request_i (write_request),
        .write_address_i (write_address),
        .write_data_i    (write_data),
        .write_strobe_i  (write_strobe),
        .read_request_i  (read_request),
        .read_address_i  (read_address),
        .write_done_o    (write_done),
        .write_error_o   (write_error),
        .read_data_o     (read_data),
        .read_valid_o    (read_valid),
        .read_error_o    (read_error)
    );

endmodule : axi_lite_mem_top

// ==== verification/axi_lite_checker.sv ====
`timescale 1ns/1ns

module axi_lite_checker import axi_lite_pkg::*; (
    input  logic              read_channel,
    input  logic              rst_n_i,

    // Expected response, one push per request
    input  logic              exp_push_i,
    input  logic              exp_write_i,
    input  logic [ADDR_W-1:0] exp_addr_i,
    input  logic [DATA_W-1:0] exp_data_i,
    input  logic [1:0]        exp_resp_i,

    // Observed DUT outputs and master readies
    input  logic              awready_i,
    input  logic              wready_i,
    input  logic              arready_i,
    input  axi_resp_t         bresp_i,
    input  logic              bvalid_i,
    input  logic              bready_i,
    input  logic [DATA_W-1:0] rdata_i,
    input  axi_resp_t         rresp_i,
    input  logic              rvalid_i,
    input  logic              rready_i,

    // Totals for the closing line
    output int                pass_count_o,
    output int                fail_count_o,
    output int                protocol_errors_o,
    output int                pending_o
);

    // Expected responses in request order
    logic              exp_write_q [$];
    logic [ADDR_W-1:0] exp_addr_q  [$];
    logic [DATA_W-1:0] exp_data_q  [$];
    logic [1:0]        exp_resp_q  [$];

    int                test_count      = 0;
    int                pass_count      = 0;
    int                fail_count      = 0;
    int                protocol_errors = 0;
    int                pending         = 0;
    logic              reset_checked   = 1'b0;
    logic              b_wait          = 1'b0;  // B valid, not yet taken
    logic              r_wait          = 1'b0;
    axi_resp_t         b_held;
    axi_resp_t         r_held;
    logic [DATA_W-1:0] r_held_data;

    assign pass_count_o      = pass_count;
    assign fail_count_o      = fail_count;
    assign protocol_errors_o = protocol_errors;
    assign pending_o         = pending;

    ////////////////////////////////////////////////////////////////////////////
    // Per-test comparisons
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_reset_state();
        test_count++;
        if (awready_i && wready_i && arready_i && !bvalid_i && !rvalid_i && bresp_i == OKAY) begin
            pass_count++;
            $display("test %0d: reset state ok", test_count);
        end else begin
            fail_count++;
            $display("ERROR %0t: test %0d after reset expected ready 111 valid 00, got %b%b%b %b%b",
                     $time, test_count, awready_i, wready_i, arready_i, bvalid_i, rvalid_i);
        end
    endtask

    // Both channels share one ordered queue
    task automatic compare_response(input logic is_write);
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [1:0]        resp;
        logic              ok;
        exp_write_q.delete(0);              // Channel already matched when valid rose
        addr       = exp_addr_q.pop_front();
        data       = exp_data_q.pop_front();
        resp       = exp_resp_q.pop_front();
        test_count++;
        if (is_write) begin
            ok = (bresp_i === resp);
        end else begin
            ok = (rresp_i === resp) && (rdata_i === data);
        end
        if (ok) begin
            pass_count++;
            $display("test %0d: %s 0x%08h resp %b ok", test_count,
                     is_write ? "write" : "read ", addr, resp);
        end else if (is_write) begin
            fail_count++;
            $display("ERROR %0t: test %0d write 0x%08h expected resp %b, got %b",
                     $time, test_count, addr, resp, bresp_i);
        end else begin
            fail_count++;
            $display("ERROR %0t: test %0d read 0x%08h expected %08h/%b, got %08h/%b",
                     $time, test_count, addr, data, resp, rdata_i, rresp_i);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Bus monitor, sampled mid-cycle
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge read_channel) begin : monitor
        if (!rst_n_i) begin
            reset_checked = 1'b0;
            b_wait        = 1'b0;
            r_wait        = 1'b0;
        end else begin
            if (!reset_checked) begin
                check_reset_state();
                reset_checked = 1'b1;
            end
            if (exp_push_i) begin
                exp_write_q.push_back(exp_write_i);
                exp_addr_q.push_back(exp_addr_i);
                exp_data_q.push_back(exp_data_i);
                exp_resp_q.push_back(exp_resp_i);
            end

            // Held responses must not move before the handshake
            if (b_wait && (!bvalid_i || bresp_i !== b_held)) begin
                protocol_errors++;
                $display("ERROR %0t: B response dropped or changed before it was taken", $time);
            end
            if (r_wait && (!rvalid_i || rresp_i !== r_held || rdata_i !== r_held_data)) begin
                protocol_errors++;
                $display("ERROR %0t: R response dropped or changed before it was taken", $time);
            end

            // A fresh response needs a request of its own kind at the queue head
            if (bvalid_i && !b_wait && !(exp_write_q.size() > 0 && exp_write_q[0])) begin
                protocol_errors++;
                $display("A write response appeared at %0t with no write outstanding", $time);
            end
            if (rvalid_i && !r_wait && !(exp_write_q.size() > 0 && !exp_write_q[0])) begin
                protocol_errors++;
                $display("A read response appeared at %0t with no read outstanding", $time);
            end

            if (bvalid_i && bready_i) compare_response(1'b1);   // Edge ahead takes B
            if (rvalid_i && rready_i) compare_response(1'b0);

            b_wait      = bvalid_i && !bready_i;
            b_held      = bresp_i;
            r_wait      = rvalid_i && !rready_i;
            r_held      = rresp_i;
            r_held_data = rdata_i;
        end
        pending = exp_write_q.size();
    end : monitor

endmodule : axi_lite_checker

// ==== verification/tb_axi_lite_mem.sv ====
`timescale 1ns/1ns

module tb_axi_lite_mem import axi_lite_pkg::*; ();

    localparam int          MEM_DEPTH = 64;
    localparam int          MAX_LINES = 64;
    localparam int          COLS      = 6;      // op, addr, data, strb, exp data, exp resp
    localparam logic [31:0] OP_WRITE  = 32'h1;
    localparam logic [31:0] OP_SWEEP  = 32'h2;  // Reads data-column words from addr up
    localparam logic [31:0] OP_END    = 32'hF;

    logic              read_channel;
    logic              rst_n;

    // Master side of the bus
    logic [ADDR_W-1:0] awaddr;
    logic              awvalid, awready;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
    logic              wvalid, wready;
    axi_resp_t         bresp;
    logic              bvalid, bready;
    logic [ADDR_W-1:0] araddr;
    logic              arvalid, arready;
    logic [DATA_W-1:0] rdata;
    axi_resp_t         rresp;
    logic              rvalid, rready;

    // Expected values to the checker
    logic              exp_push, exp_write;
    logic [ADDR_W-1:0] exp_addr;
    logic [DATA_W-1:0] exp_data;
    logic [1:0]        exp_resp;

    logic [31:0]       stim_mem [COLS*MAX_LINES];
    logic [31:0]       lfsr_state  = 32'h9061;
    int                cycle_count = 0;
    int                cycle_limit = 0;
    int                total_tests = 0;
    int                pass_count, fail_count, protocol_errors, pending;

    axi_lite_mem_top #(
        .MEM_DEPTH (MEM_DEPTH),
        .BASE_ADDR ('0)
    ) u_axi_lite_mem_top (
        .read_channel (read_channel), .rst_n_i   (rst_n),
        .awaddr_i     (awaddr),       .awvalid_i (awvalid), .awready_o (awready),
        .wdata_i      (wdata),        .wstrb_i   (wstrb),
        .wvalid_i     (wvalid),       .wready_o  (wready),
        .bresp_o      (bresp),        .bvalid_o  (bvalid),  .bready_i  (bready),
        .araddr_i     (araddr),       .arvalid_i (arvalid), .arready_o (arready),
        .rdata_o      (rdata),        .rresp_o   (rresp),
        .rvalid_o     (rvalid),       .rready_i  (rready)
    );

    axi_lite_checker u_checker (
        .read_channel (read_channel), .rst_n_i    (rst_n),
        .exp_push_i   (exp_push),     .exp_write_i (exp_write),
        .exp_addr_i   (exp_addr),     .exp_data_i (exp_data), .exp_resp_i (exp_resp),
        .awready_i    (awready),      .wready_i   (wready),   .arready_i  (arready),
        .bresp_i      (bresp),        .bvalid_i   (bvalid),   .bready_i   (bready),
        .rdata_i      (rdata),        .rresp_i    (rresp),
        .rvalid_i     (rvalid),       .rready_i   (rready),
        .pass_count_o (pass_count),   .fail_count_o (fail_count),
        .protocol_errors_o (protocol_errors), .pending_o (pending)
    );

    initial begin : clock_gen
        read_channel = 1'b0;
        forever #50 read_channel = ~read_channel;   // 100 ns period
    end : clock_gen

    ////////////////////////////////////////////////////////////////////////////
    // Random back-pressure
    ////////////////////////////////////////////////////////////////////////////

    // Galois LFSR, one step per bit
    function automatic logic lfsr_bit();
        logic out_bit;
        out_bit    = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out_bit) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return out_bit;
    endfunction

    function automatic int ready_delay();
        logic [1:0] d;
        d[1] = lfsr_bit();
        d[0] = lfsr_bit();
        return d;               // 0 to 3 cycles
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Master tasks, entered just after a rising edge
    ////////////////////////////////////////////////////////////////////////////

    task automatic send_request(input logic is_write, input logic [31:0] addr, data,
                                input logic [3:0] strb, input logic [31:0] want,
                                input logic [1:0] resp);
        logic accepted;
        exp_push  <= 1'b1;                  // One-cycle pulse into the checker queue
        exp_write <= is_write;
        exp_addr  <= addr;
        exp_data  <= want;
        exp_resp  <= resp;
        if (is_write) begin
            awaddr  <= addr;
            awvalid <= 1'b1;
            wdata   <= data;
            wstrb   <= strb;
            wvalid  <= 1'b1;                // AW and W together
        end else begin
            araddr  <= addr;
            arvalid <= 1'b1;
        end
        @(negedge read_channel);
        accepted = is_write ? (awready && wready) : arready;
        @(posedge read_channel);
        exp_push <= 1'b0;
        while (!accepted) begin
            @(negedge read_channel);
            accepted = is_write ? (awready && wready) : arready;
            @(posedge read_channel);
        end
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        arvalid <= 1'b0;
    endtask

    task automatic take_response(input logic is_write);
        int delay;
        do begin
            @(negedge read_channel);
        end while (!(is_write ? bvalid : rvalid));
        delay = ready_delay();
        repeat (delay) @(negedge read_channel);     // Response must stay put meanwhile
        @(posedge read_channel);
        if (is_write) bready <= 1'b1;
        else          rready <= 1'b1;
        @(posedge read_channel);                    // Handshake on this edge
        bready <= 1'b0;
        rready <= 1'b0;
    endtask

    task automatic run_line(input int n);
        logic [31:0] op, addr, data, strb, want, resp;
        op   = stim_mem[COLS*n];
        addr = stim_mem[COLS*n+1];
        data = stim_mem[COLS*n+2];
        strb = stim_mem[COLS*n+3];
        want = stim_mem[COLS*n+4];
        resp = stim_mem[COLS*n+5];
        if (op == OP_SWEEP) begin
            for (int k = 0; k < data; k++) begin
                send_request(1'b0, addr + 4*k, '0, '0, want, resp[1:0]);
                take_response(1'b0);
            end
        end else begin
            send_request(op == OP_WRITE, addr, data, strb[3:0], want, resp[1:0]);
            take_response(op == OP_WRITE);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin : run
        int n_lines;
        rst_n    = 1'b0;
        awaddr   = '0;
        awvalid  = 1'b0;
        wdata    = '0;
        wstrb    = '0;
        wvalid   = 1'b0;
        bready   = 1'b0;
        araddr   = '0;
        arvalid  = 1'b0;
        rready   = 1'b0;
        exp_push = 1'b0;
        exp_write = 1'b0;
        exp_addr = '0;
        exp_data = '0;
        exp_resp = '0;

        $readmemh("verification/axi_lite_stimulus.txt", stim_mem);
        total_tests = 1;                    // Reset state
        n_lines     = 0;
        while (n_lines < MAX_LINES && stim_mem[COLS*n_lines] != OP_END) begin
            total_tests += (stim_mem[COLS*n_lines] == OP_SWEEP) ? stim_mem[COLS*n_lines+2] : 1;
            n_lines++;
        end
        cycle_limit = total_tests * 12 + 50;

        repeat (10) @(posedge read_channel);
        rst_n <= 1'b1;
        @(posedge read_channel);            // Idle cycle after reset

        for (int i = 0; i < n_lines; i++) begin
            run_line(i);
        end
        @(negedge read_channel);            // Checker sees the last handshake
        @(posedge read_channel);

        $display("Summary: %0d passed, %0d failed, %0d protocol errors, %0d pending, %0d expected",
                 pass_count, fail_count, protocol_errors, pending, total_tests);
        if (fail_count == 0 && protocol_errors == 0 && pending == 0
            && pass_count == total_tests) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end : run

    // Cycle budget scales with the number of transactions
    initial begin : watchdog
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge read_channel);
            cycle_count++;
        end
        $display("Run timed out after %0d cycles without finishing all tests", cycle_count);
        $display(">>> FAIL");
        $finish;
    end : watchdog

endmodule : tb_axi_lite_mem

// ==== verification/axi_lite_stimulus.txt ====
// Columns: op addr data strb exp_data exp_resp, all hex
// op 0 read, 1 write, 2 read sweep (data column is the word count), F ends the list
// After reset every word reads zero
2 00000000 00000040 0 00000000 0
// Full-strobe write and read back
1 00000010 DEADBEEF F 00000000 0
0 00000010 00000000 0 DEADBEEF 0
1 000000FC 12345678 F 00000000 0
0 000000FC 00000000 0 12345678 0
// Partial strobes replace only the enabled lanes
1 00000010 AABBCCDD 1 00000000 0
0 00000010 00000000 0 DEADBEDD 0
1 00000010 11223344 6 00000000 0
0 00000010 00000000 0 DE2233DD 0
1 00000010 99000000 8 00000000 0
0 00000010 00000000 0 992233DD 0
1 00000020 CAFEF00D 3 00000000 0
0 00000020 00000000 0 0000F00D 0
// Out of range and unaligned accesses
1 00000100 FFFFFFFF F 00000000 2
1 00000012 FFFFFFFF F 00000000 2
0 00000010 00000000 0 992233DD 0
0 000000FC 00000000 0 12345678 0
0 00000100 00000000 0 00000000 2
0 00000013 00000000 0 00000000 2
0 FFFFFFFC 00000000 0 00000000 2
// Mixed traffic under random ready delays
1 00000004 01020304 F 00000000 0
1 00000008 05060708 F 00000000 0
0 00000004 00000000 0 01020304 0
0 00000008 00000000 0 05060708 0
1 0000000C A5A5A5A5 5 00000000 0
0 0000000C 00000000 0 00A500A5 0
1 0000000C 5A5A5A5A A 00000000 0
0 0000000C 00000000 0 5AA55AA5 0
F 00000000 00000000 0 00000000 0

// ==== build.f ====
common/axi_lite_pkg.sv
axi_slave/axi_slave.sv
hdl/access_sequencer.sv
hdl/mem_bank.sv
hdl/axi_lite_mem_top.sv
verification/axi_lite_checker.sv
verification/tb_axi_lite_mem.sv
